/* rs_pkg.sv */
package rs_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////
    localparam int XLEN           = 32;  // operand and pc width
    localparam int RS_SIZE        = 8;   // station slots, slot 0 oldest
    localparam int RS_CNT_BITS    = 4;   // holds 0..RS_SIZE
    localparam int ROB_TAG_BITS   = 5;   // rob index width
    localparam int DISPATCH_WIDTH = 2;   // dispatch lanes
    localparam int CDB_WIDTH      = 2;   // broadcast ports

    ////////////////////////////////////////////////////////////
    // enums
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_NONE  = 2'd0,  // hold or shift
        SEL_LANE0 = 2'd1,  // take lane 0 entry
        SEL_LANE1 = 2'd2   // take lane 1 entry
    } alloc_sel_e;

    ////////////////////////////////////////////////////////////
    // packets
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                     en;         // lane carries an instruction
        logic [XLEN-1:0]          pc;
        alu_op_e                  alu_op;
        logic                     rd_mem;     // load
        logic                     rs1_exist;  // has a real rs1
        logic                     rs2_exist;  // has a real rs2
        logic [XLEN-1:0]          rs1_value;  // regfile value
        logic [XLEN-1:0]          rs2_value;
    } dispatch_t;

    typedef struct packed {
        logic [ROB_TAG_BITS-1:0]  tag1;
        logic [ROB_TAG_BITS-1:0]  tag2;
        logic                     tag1_valid;         // rs1 renamed
        logic                     tag2_valid;         // rs2 renamed
        logic                     tag1_ready_in_rob;  // value already sits in rob
        logic                     tag2_ready_in_rob;
    } map_t;

    typedef struct packed {
        logic [ROB_TAG_BITS-1:0]  tag;        // rob slot given to this inst
        logic [XLEN-1:0]          rs1_value;  // rob read of tag1
        logic [XLEN-1:0]          rs2_value;  // rob read of tag2
    } rob_t;

    typedef struct packed {
        logic                     valid;
        logic [ROB_TAG_BITS-1:0]  tag;
        logic [XLEN-1:0]          value;
    } cdb_t;

    typedef struct packed {
        logic                     busy;
        logic [XLEN-1:0]          pc;
        alu_op_e                  alu_op;
        logic                     rd_mem;
        logic                     rs1_exist;
        logic                     rs2_exist;
        logic [ROB_TAG_BITS-1:0]  tag;         // own rob tag
        logic [ROB_TAG_BITS-1:0]  tag1;        // producer of rs1
        logic [ROB_TAG_BITS-1:0]  tag2;        // producer of rs2
        logic                     tag1_valid;  // still waiting on tag1
        logic                     tag2_valid;  // still waiting on tag2
        logic [XLEN-1:0]          rs1_value;
        logic [XLEN-1:0]          rs2_value;
    } rs_entry_t;

    typedef struct packed {
        logic [XLEN-1:0]          pc;
        alu_op_e                  alu_op;
        logic                     rd_mem;
        logic [ROB_TAG_BITS-1:0]  tag;
        logic [XLEN-1:0]          rs1_value;
        logic [XLEN-1:0]          rs2_value;
    } issue_t;

    localparam rs_entry_t rs_entry_empty = '{
        busy       : 1'b0,
        pc         : '0,
        alu_op     : ALU_ADD,
        rd_mem     : 1'b0,
        rs1_exist  : 1'b1,   // empty slot looks operand-complete
        rs2_exist  : 1'b1,
        tag        : '0,
        tag1       : '0,
        tag2       : '0,
        tag1_valid : 1'b0,
        tag2_valid : 1'b0,
        rs1_value  : '0,
        rs2_value  : '0
    };

endpackage

/* rs_slot.sv */
`timescale 1ns/1ps

module rs_slot (
    input  logic                                           clock,
    input  logic                                           reset,
    input  logic                                           squash,
    input  logic                                           shift,             // take entry_above
    input  rs_pkg::rs_entry_t                              entry_above,
    input  rs_pkg::alloc_sel_e                             alloc_sel,
    input  rs_pkg::rs_entry_t [rs_pkg::DISPATCH_WIDTH-1:0] new_entry,
    input  rs_pkg::cdb_t      [rs_pkg::CDB_WIDTH-1:0]      cdb,
    input  logic                                           has_ld_from_above, // older load somewhere
    output rs_pkg::rs_entry_t                              entry,
    output logic                                           ready,
    output logic                                           has_ld_incl_self
);

    rs_pkg::rs_entry_t base_entry;   // after hold/shift
    rs_pkg::rs_entry_t alloc_entry;  // after allocation
    rs_pkg::rs_entry_t next_entry;   // after cdb wakeup
    logic              rs1_wait;     // rs1 still outstanding
    logic              rs2_wait;     // rs2 still outstanding
    logic              ld_blocked;   // load behind an older load

    ////////////////////////////////////////////////////////////
    // next-state selection
    ////////////////////////////////////////////////////////////

    // squeeze toward slot 0, one position at most
    assign base_entry = shift ? entry_above : entry;

    always_comb begin
        unique case (alloc_sel)
            rs_pkg::SEL_LANE0: alloc_entry = new_entry[0];  // lane 0 lands here
            rs_pkg::SEL_LANE1: alloc_entry = new_entry[1];  // lane 1 lands here
            default:           alloc_entry = base_entry;    // no allocation
        endcase
    end

    // tag match on every port, port 0 wins a double hit
    always_comb begin
        next_entry = alloc_entry;
        for (int p = rs_pkg::CDB_WIDTH - 1; p >= 0; p--) begin
            if (cdb[p].valid && alloc_entry.tag1_valid &&
                cdb[p].tag == alloc_entry.tag1) begin
                next_entry.rs1_value  = cdb[p].value;  // capture broadcast
                next_entry.tag1_valid = 1'b0;          // operand resolved
            end
            if (cdb[p].valid && alloc_entry.tag2_valid &&
                cdb[p].tag == alloc_entry.tag2) begin
                next_entry.rs2_value  = cdb[p].value;
                next_entry.tag2_valid = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // entry register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            entry <= rs_pkg::rs_entry_empty;  // slot freed
        end else begin
            entry <= next_entry;
        end
    end

    ////////////////////////////////////////////////////////////
    // readiness and load chain
    ////////////////////////////////////////////////////////////
    assign rs1_wait   = entry.rs1_exist & entry.tag1_valid;
    assign rs2_wait   = entry.rs2_exist & entry.tag2_valid;
    assign ld_blocked = entry.rd_mem & has_ld_from_above;  // loads stay in order

    assign ready = entry.busy & ~rs1_wait & ~rs2_wait & ~ld_blocked;

    // pass the load flag to the next younger slot
    assign has_ld_incl_self = has_ld_from_above | (entry.busy & entry.rd_mem);

endmodule

/* rs_dispatch_ctrl.sv */
`timescale 1ns/1ps

module rs_dispatch_ctrl (
    input  rs_pkg::dispatch_t  [rs_pkg::DISPATCH_WIDTH-1:0] dispatch,
    input  rs_pkg::map_t       [rs_pkg::DISPATCH_WIDTH-1:0] map,
    input  rs_pkg::rob_t       [rs_pkg::DISPATCH_WIDTH-1:0] rob,
    input  logic               [rs_pkg::RS_SIZE-1:0]        busy,
    input  logic                                            issue_fire,  // squeeze this cycle
    output rs_pkg::rs_entry_t  [rs_pkg::DISPATCH_WIDTH-1:0] new_entry,
    output rs_pkg::alloc_sel_e [rs_pkg::RS_SIZE-1:0]        alloc_sel,
    output logic               [rs_pkg::RS_CNT_BITS-1:0]    free_count
);

    logic [rs_pkg::RS_CNT_BITS-1:0] busy_count;  // occupied slots, registered state
    logic [rs_pkg::RS_CNT_BITS-1:0] base;        // first free slot after squeeze
    logic                           lane0_ok;
    logic                           lane1_ok;    // lane 1 needs lane 0

    ////////////////////////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////////////////////////
    always_comb begin
        busy_count = '0;
        for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
            busy_count = busy_count + {{(rs_pkg::RS_CNT_BITS - 1){1'b0}}, busy[i]};
        end
    end

    assign free_count = rs_pkg::RS_CNT_BITS'(rs_pkg::RS_SIZE) - busy_count;
    assign base       = busy_count - {{(rs_pkg::RS_CNT_BITS - 1){1'b0}}, issue_fire};
    assign lane0_ok   = dispatch[0].en;
    assign lane1_ok   = dispatch[0].en & dispatch[1].en;

    // slot choice, lanes past the top are dropped
    always_comb begin
        for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
            if (lane0_ok && i == int'(base)) begin
                alloc_sel[i] = rs_pkg::SEL_LANE0;
            end else if (lane1_ok && i == int'(base) + 1) begin
                alloc_sel[i] = rs_pkg::SEL_LANE1;
            end else begin
                alloc_sel[i] = rs_pkg::SEL_NONE;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // entry build with rob bypass
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int l = 0; l < rs_pkg::DISPATCH_WIDTH; l++) begin
            new_entry[l].busy       = 1'b1;
            new_entry[l].pc         = dispatch[l].pc;
            new_entry[l].alu_op     = dispatch[l].alu_op;
            new_entry[l].rd_mem     = dispatch[l].rd_mem;
            new_entry[l].rs1_exist  = dispatch[l].rs1_exist;
            new_entry[l].rs2_exist  = dispatch[l].rs2_exist;
            new_entry[l].tag        = rob[l].tag;          // own rob slot
            new_entry[l].tag1       = map[l].tag1;
            new_entry[l].tag2       = map[l].tag2;
            new_entry[l].tag1_valid = map[l].tag1_valid & ~map[l].tag1_ready_in_rob;
            new_entry[l].tag2_valid = map[l].tag2_valid & ~map[l].tag2_ready_in_rob;
            new_entry[l].rs1_value  = map[l].tag1_ready_in_rob ? rob[l].rs1_value
                                                               : dispatch[l].rs1_value;
            new_entry[l].rs2_value  = map[l].tag2_ready_in_rob ? rob[l].rs2_value
                                                               : dispatch[l].rs2_value;
        end
    end

endmodule

/* rs_issue_select.sv */
`timescale 1ns/1ps

module rs_issue_select (
    input  logic              [rs_pkg::RS_SIZE-1:0] ready,
    input  rs_pkg::rs_entry_t [rs_pkg::RS_SIZE-1:0] entries,
    input  logic                                    fu_ready,     // level from the fu
    output logic                                    issue_valid,
    output rs_pkg::issue_t                          issue,
    output logic                                    issue_fire,   // drives the squeeze
    output logic              [rs_pkg::RS_SIZE-1:0] shift
);

    logic [rs_pkg::RS_CNT_BITS-1:0] sel_idx;    // oldest ready slot
    logic                           any_ready;
    rs_pkg::rs_entry_t              sel_entry;

    ////////////////////////////////////////////////////////////
    // oldest-ready pick
    ////////////////////////////////////////////////////////////

    // scan from the top so the lowest index wins
    always_comb begin
        sel_idx   = '0;
        any_ready = 1'b0;
        for (int i = rs_pkg::RS_SIZE - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel_idx   = i[rs_pkg::RS_CNT_BITS-1:0];
                any_ready = 1'b1;
            end
        end
    end

    assign issue_fire  = any_ready & fu_ready;  // nothing leaves under back-pressure
    assign issue_valid = issue_fire;

    assign sel_entry = entries[sel_idx[rs_pkg::RS_CNT_BITS-2:0]];

    ////////////////////////////////////////////////////////////
    // issue packet
    ////////////////////////////////////////////////////////////
    always_comb begin
        issue.pc        = sel_entry.pc;
        issue.alu_op    = sel_entry.alu_op;
        issue.rd_mem    = sel_entry.rd_mem;
        issue.tag       = sel_entry.tag;        // rob slot for writeback
        issue.rs1_value = sel_entry.rs1_value;
        issue.rs2_value = sel_entry.rs2_value;
    end

    // every slot from the issued one upward moves down by one
    always_comb begin
        for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
            shift[i] = issue_fire & (i >= int'(sel_idx));
        end
    end

endmodule

/* rs_station.sv */
`timescale 1ns/1ps

module rs_station (
    input  logic                                           clock,
    input  logic                                           reset,
    input  logic                                           squash,      // flush all slots
    input  rs_pkg::dispatch_t [rs_pkg::DISPATCH_WIDTH-1:0] dispatch,
    input  rs_pkg::map_t      [rs_pkg::DISPATCH_WIDTH-1:0] map,
    input  rs_pkg::rob_t      [rs_pkg::DISPATCH_WIDTH-1:0] rob,
    input  rs_pkg::cdb_t      [rs_pkg::CDB_WIDTH-1:0]      cdb,
    input  logic                                           fu_ready,
    output logic                                           issue_valid,
    output rs_pkg::issue_t                                 issue,
    output logic              [rs_pkg::RS_CNT_BITS-1:0]    free_count
);

    rs_pkg::rs_entry_t  [rs_pkg::DISPATCH_WIDTH-1:0] new_entry;    // built per lane
    rs_pkg::alloc_sel_e [rs_pkg::RS_SIZE-1:0]        alloc_sel;    // per-slot load choice
    rs_pkg::rs_entry_t  [rs_pkg::RS_SIZE-1:0]        entries;      // slot contents
    rs_pkg::rs_entry_t  [rs_pkg::RS_SIZE-1:0]        entry_above;  // squeeze source
    logic               [rs_pkg::RS_SIZE-1:0]        busy;
    logic               [rs_pkg::RS_SIZE-1:0]        ready;
    logic               [rs_pkg::RS_SIZE-1:0]        shift;
    logic               [rs_pkg::RS_SIZE-1:0]        ld_chain;     // load seen at or below
    logic                                            issue_fire;

    ////////////////////////////////////////////////////////////
    // dispatch side
    ////////////////////////////////////////////////////////////
    rs_dispatch_ctrl dispatch_ctrl0 (
        .dispatch   (dispatch),
        .map        (map),
        .rob        (rob),
        .busy       (busy),
        .issue_fire (issue_fire),
        .new_entry  (new_entry),
        .alloc_sel  (alloc_sel),
        .free_count (free_count)
    );

    ////////////////////////////////////////////////////////////
    // slots, 0 oldest
    ////////////////////////////////////////////////////////////
    for (genvar i = 0; i < rs_pkg::RS_SIZE; i++) begin : g_slot
        if (i == rs_pkg::RS_SIZE - 1) begin : g_top
            assign entry_above[i] = rs_pkg::rs_entry_empty;  // top refills empty
        end else begin : g_mid
            assign entry_above[i] = entries[i+1];
        end

        assign busy[i] = entries[i].busy;

        rs_slot slot0 (
            .clock             (clock),
            .reset             (reset),
            .squash            (squash),
            .shift             (shift[i]),
            .entry_above       (entry_above[i]),
            .alloc_sel         (alloc_sel[i]),
            .new_entry         (new_entry),
            .cdb               (cdb),
            .has_ld_from_above ((i == 0) ? 1'b0 : ld_chain[(i == 0) ? 0 : i-1]),
            .entry             (entries[i]),
            .ready             (ready[i]),
            .has_ld_incl_self  (ld_chain[i])
        );
    end

    ////////////////////////////////////////////////////////////
    // issue side
    ////////////////////////////////////////////////////////////
    rs_issue_select issue_select0 (
        .ready       (ready),
        .entries     (entries),
        .fu_ready    (fu_ready),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_fire  (issue_fire),
        .shift       (shift)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    localparam int HALF_PERIOD = 20;  // 40 ns clock

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // three edges in reset, release just after the third
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule

/* tb_rs_station.sv */
`timescale 1ns/1ps

module tb_rs_station;

    localparam int RANDOM_CYCLES = 200;  // mixed traffic phase
    localparam int DRAIN_LIMIT   = 40;   // cycles allowed to empty the station
    localparam int TEST_CYCLES   = 60 + RANDOM_CYCLES + 6 * DRAIN_LIMIT;

    logic                                           clock;
    logic                                           reset;
    logic                                           squash;
    rs_pkg::dispatch_t [rs_pkg::DISPATCH_WIDTH-1:0] dispatch;
    rs_pkg::map_t      [rs_pkg::DISPATCH_WIDTH-1:0] map;
    rs_pkg::rob_t      [rs_pkg::DISPATCH_WIDTH-1:0] rob;
    rs_pkg::cdb_t      [rs_pkg::CDB_WIDTH-1:0]      cdb;
    logic                                           fu_ready;
    logic                                           issue_valid;
    rs_pkg::issue_t                                 issue;
    logic              [rs_pkg::RS_CNT_BITS-1:0]    free_count;

    rs_pkg::rs_entry_t                 model_q[$];   // age order, front oldest
    logic [rs_pkg::ROB_TAG_BITS-1:0]   pending[$];   // tags still to broadcast
    logic [rs_pkg::ROB_TAG_BITS-1:0]   rob_tag;      // next rob slot handed out
    logic [31:0]                       lfsr;
    logic                              exp_valid;
    rs_pkg::issue_t                    exp_issue;
    logic [rs_pkg::RS_CNT_BITS-1:0]    exp_free;
    int                                exp_idx;      // model index that leaves
    int                                error_count;
    int                                issue_count;

    tb_clock_gen clock_gen0 (
        .clock (clock),
        .reset (reset)
    );

    rs_station dut0 (
        .clock       (clock),
        .reset       (reset),
        .squash      (squash),
        .dispatch    (dispatch),
        .map         (map),
        .rob         (rob),
        .cdb         (cdb),
        .fu_ready    (fu_ready),
        .issue_valid (issue_valid),
        .issue       (issue),
        .free_count  (free_count)
    );

    ////////////////////////////////////////////////////////////
    // checks at the falling edge, inputs and outputs settled
    ////////////////////////////////////////////////////////////
    assert property (@(negedge clock) issue_valid == exp_valid)
        else begin
            $display("[ERROR] %0t issue_valid expected %0b actual %0b",
                     $time, exp_valid, issue_valid);
            error_count++;
        end

    assert property (@(negedge clock) !exp_valid || issue == exp_issue)
        else begin
            $display("[ERROR] %0t issue expected %h actual %h", $time, exp_issue, issue);
            error_count++;
        end

    assert property (@(negedge clock) free_count == exp_free)
        else begin
            $display("[ERROR] %0t free_count expected %0d actual %0d",
                     $time, exp_free, free_count);
            error_count++;
        end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = rand_bits(1);
        return r[0];
    endfunction

    // new entry as the station should store it
    function automatic rs_pkg::rs_entry_t build_entry(input int l);
        rs_pkg::rs_entry_t e;
        e.busy       = 1'b1;
        e.pc         = dispatch[l].pc;
        e.alu_op     = dispatch[l].alu_op;
        e.rd_mem     = dispatch[l].rd_mem;
        e.rs1_exist  = dispatch[l].rs1_exist;
        e.rs2_exist  = dispatch[l].rs2_exist;
        e.tag        = rob[l].tag;
        e.tag1       = map[l].tag1;
        e.tag2       = map[l].tag2;
        e.tag1_valid = map[l].tag1_valid && !map[l].tag1_ready_in_rob;  // pending only
        e.tag2_valid = map[l].tag2_valid && !map[l].tag2_ready_in_rob;
        e.rs1_value  = map[l].tag1_ready_in_rob ? rob[l].rs1_value : dispatch[l].rs1_value;
        e.rs2_value  = map[l].tag2_ready_in_rob ? rob[l].rs2_value : dispatch[l].rs2_value;
        return e;
    endfunction

    // model step at the rising edge, inputs still hold last cycle's values
    task automatic advance_model();
        rs_pkg::rs_entry_t e;
        if (reset || squash) begin
            model_q.delete();
            return;
        end
        if (exp_valid) begin
            model_q.delete(exp_idx);  // squeeze keeps age order
            issue_count++;
        end
        if (dispatch[0].en && model_q.size() < rs_pkg::RS_SIZE) model_q.push_back(build_entry(0));
        if (dispatch[0].en && dispatch[1].en && model_q.size() < rs_pkg::RS_SIZE)
            model_q.push_back(build_entry(1));
        foreach (model_q[i]) begin
            e = model_q[i];
            for (int p = 0; p < rs_pkg::CDB_WIDTH; p++) begin  // port 0 first
                if (cdb[p].valid && e.tag1_valid && cdb[p].tag == e.tag1) begin
                    e.rs1_value  = cdb[p].value;
                    e.tag1_valid = 1'b0;
                end
                if (cdb[p].valid && e.tag2_valid && cdb[p].tag == e.tag2) begin
                    e.rs2_value  = cdb[p].value;
                    e.tag2_valid = 1'b0;
                end
            end
            model_q[i] = e;
        end
    endtask

    // expected outputs for the cycle just driven
    task automatic settle();
        logic ld_seen;  // older load still held
        logic rdy;
        ld_seen = 1'b0;
        exp_idx = -1;
        foreach (model_q[i]) begin
            rdy = !(model_q[i].rs1_exist && model_q[i].tag1_valid) &&
                  !(model_q[i].rs2_exist && model_q[i].tag2_valid) &&
                  !(model_q[i].rd_mem && ld_seen);
            if (exp_idx < 0 && rdy) exp_idx = i;
            if (model_q[i].rd_mem) ld_seen = 1'b1;
        end
        exp_valid = (exp_idx >= 0) && fu_ready;
        exp_free  = rs_pkg::RS_CNT_BITS'(rs_pkg::RS_SIZE - model_q.size());
        exp_issue = '0;
        if (exp_valid) begin
            exp_issue.pc        = model_q[exp_idx].pc;
            exp_issue.alu_op    = model_q[exp_idx].alu_op;
            exp_issue.rd_mem    = model_q[exp_idx].rd_mem;
            exp_issue.tag       = model_q[exp_idx].tag;
            exp_issue.rs1_value = model_q[exp_idx].rs1_value;
            exp_issue.rs2_value = model_q[exp_idx].rs2_value;
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        advance_model();
        #2;              // drive after the edge
        squash   = 1'b0;
        dispatch = '0;
        map      = '0;
        rob      = '0;
        cdb      = '0;
    endtask

    task automatic add_inst(input int l, input logic ld, input logic w1, input logic w2);
        logic by1;
        logic by2;
        by1 = !w1 && rand_bit();  // value already in the rob
        by2 = !w2 && rand_bit();
        dispatch[l].en        = 1'b1;
        dispatch[l].pc        = rand_bits(32);
        dispatch[l].alu_op    = rs_pkg::alu_op_e'(3'(rand_bits(3)));
        dispatch[l].rd_mem    = ld;
        dispatch[l].rs1_exist = w1 || by1 || rand_bit();
        dispatch[l].rs2_exist = w2 || by2 || rand_bit();
        dispatch[l].rs1_value = rand_bits(32);
        dispatch[l].rs2_value = rand_bits(32);
        map[l].tag1              = rs_pkg::ROB_TAG_BITS'(rand_bits(rs_pkg::ROB_TAG_BITS));
        map[l].tag2              = rs_pkg::ROB_TAG_BITS'(rand_bits(rs_pkg::ROB_TAG_BITS));
        map[l].tag1_valid        = w1 || by1;
        map[l].tag2_valid        = w2 || by2;
        map[l].tag1_ready_in_rob = by1;
        map[l].tag2_ready_in_rob = by2;
        rob[l].tag       = rob_tag;
        rob[l].rs1_value = rand_bits(32);
        rob[l].rs2_value = rand_bits(32);
        rob_tag = rob_tag + 1'b1;
        if (w1) pending.push_back(map[l].tag1);
        if (w2) pending.push_back(map[l].tag2);
    endtask

    // levels are out of 4: chance that rand_bits(2) falls below
    task automatic dispatch_some(input int n, input int wait_lvl, input int ld_lvl);
        int room;
        room = rs_pkg::RS_SIZE - model_q.size();  // free_count this cycle
        for (int l = 0; l < n && l < room; l++) begin
            add_inst(l, rand_bits(2) < ld_lvl, rand_bits(2) < wait_lvl, rand_bits(2) < wait_lvl);
        end
    endtask

    task automatic broadcast(input int p, input logic [rs_pkg::ROB_TAG_BITS-1:0] tag);
        cdb[p].valid = 1'b1;
        cdb[p].tag   = tag;
        cdb[p].value = rand_bits(32);
    endtask

    task automatic wake_some(input int n);
        for (int p = 0; p < n && p < rs_pkg::CDB_WIDTH && pending.size() > 0; p++) begin
            broadcast(p, pending.pop_front());
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((model_q.size() != 0 || pending.size() != 0) && n < DRAIN_LIMIT) begin
            next_cycle();
            fu_ready = 1'b1;
            wake_some(rs_pkg::CDB_WIDTH);
            settle();
            n++;
        end
        if (model_q.size() != 0 || free_count != rs_pkg::RS_CNT_BITS'(rs_pkg::RS_SIZE)) begin
            $display("station still holds entries %0d cycles into a drain at %0t", n, $time);
            error_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        squash      = 1'b0;
        dispatch    = '0;
        map         = '0;
        rob         = '0;
        cdb         = '0;
        fu_ready    = 1'b0;
        lfsr        = 32'd92714;
        rob_tag     = '0;
        exp_valid   = 1'b0;
        exp_issue   = '0;
        exp_free    = rs_pkg::RS_CNT_BITS'(rs_pkg::RS_SIZE);
        exp_idx     = -1;
        error_count = 0;
        issue_count = 0;

        while (reset) begin  // outputs checked through reset
            next_cycle();
            fu_ready = 1'b1;                    // a kept entry would issue
            if (reset) dispatch_some(2, 0, 0);  // ready traffic the reset must drop
            settle();
        end

        // ready traffic on one or both lanes
        repeat (30) begin
            next_cycle();
            fu_ready = (rand_bits(2) != 0);
            dispatch_some(rand_bits(2) % 3, 0, 0);
            settle();
        end
        drain();

        // wakeup, younger ready entry passes the older waiting one
        next_cycle();
        fu_ready = 1'b1;
        add_inst(0, 1'b0, 1'b1, 1'b1);
        add_inst(1, 1'b0, 1'b0, 1'b0);
        settle();
        next_cycle();
        add_inst(0, 1'b0, 1'b1, 1'b0);
        broadcast(1, pending.pop_back());  // same-cycle wake, port 1 rs1
        settle();
        next_cycle();
        add_inst(0, 1'b0, 1'b0, 1'b1);
        broadcast(0, pending.pop_back());  // same-cycle wake, port 0 rs2
        settle();
        next_cycle();
        wake_some(2);                      // port 0 rs1, port 1 rs2
        settle();
        drain();

        // load ordering
        next_cycle();
        fu_ready = 1'b1;
        add_inst(0, 1'b1, 1'b1, 1'b0);     // older load waits
        add_inst(1, 1'b1, 1'b0, 1'b0);     // younger load held back
        settle();
        next_cycle();
        add_inst(0, 1'b0, 1'b0, 1'b0);     // non-load may pass
        settle();
        repeat (3) begin
            next_cycle();
            settle();
        end
        drain();

        // back-pressure fill then drain
        repeat (6) begin
            next_cycle();
            fu_ready = 1'b0;
            dispatch_some(2, 1, 1);
            wake_some(1);
            settle();
        end
        next_cycle();
        fu_ready = 1'b0;
        settle();
        if (free_count != '0) begin
            $display("station did not fill under back-pressure at %0t", $time);
            error_count++;
        end
        drain();

        // squash with entries present
        repeat (3) begin
            next_cycle();
            fu_ready = 1'b0;
            dispatch_some(2, 2, 1);
            settle();
        end
        next_cycle();
        squash = 1'b1;
        settle();
        pending.delete();
        repeat (3) begin
            next_cycle();
            fu_ready = 1'b1;
            settle();
        end

        // mixed traffic
        repeat (RANDOM_CYCLES) begin
            next_cycle();
            fu_ready = (rand_bits(2) != 0);
            squash   = (rand_bits(6) == 0);
            dispatch_some(rand_bits(2) % 3, 2, 1);
            wake_some(rand_bits(2) % 3);
            settle();
        end
        drain();

        @(negedge clock);  // last checks
        #1;                // their failures counted first
        $display("issued %0d instructions, %0d errors", issue_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TEST_CYCLES * 40 + 2000);
        $display("run exceeded %0d cycles and was stopped", TEST_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* rs_station.f */
rs_pkg.sv
rs_slot.sv
rs_dispatch_ctrl.sv
rs_issue_select.sv
rs_station.sv
tb_clock_gen.sv
tb_rs_station.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rs_station \
    -f rs_station.f -o tb_rs_station
./obj_dir/tb_rs_station > sim.log 2>&1
cat sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
